//--- Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - common
    files:
      - common/icache_pkg.sv
      - icache/icache_arrays.sv
      - icache/icache_lookup.sv
      - icache/icache_refill.sv
      - icache/icache_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/mem_model.sv
      - test/tb_icache.sv

//--- common/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry
`define ICACHE_WAYS        2
`define ICACHE_SETS        128
`define ICACHE_LINE_BEATS  8

// address split into tag, index and offset
`define ICACHE_OFFSET_BITS 5
`define ICACHE_INDEX_BITS  7
`define ICACHE_TAG_BITS    20

// two instructions per fetch group
`define ICACHE_GROUP_BITS  64

`endif

//--- common/icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    // one tag slot of a way
    typedef struct packed {
        logic                        valid;
        logic [`ICACHE_TAG_BITS-1:0] tag;
    } tag_entry_t;

    // refill controller states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        REQ   = 3'd1,
        FILL  = 3'd2,
        CACOP = 3'd3,
        HOLD  = 3'd4
    } refill_state_e;

    // index-based maintenance from commit
    typedef enum logic [1:0] {
        OP_INIT    = 2'd0,
        OP_IDX_INV = 2'd1
    } cacop_op_e;

endpackage

//--- icache/icache_arrays.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_arrays import icache_pkg::*; (
    input  logic                                            clk,
    input  logic                                            rst_n,
    // read index is set plus group position
    input  logic [`ICACHE_INDEX_BITS+1:0]                   rd_index_i,
    output tag_entry_t [`ICACHE_WAYS-1:0]                   rd_tags_o,
    output logic [`ICACHE_WAYS-1:0][`ICACHE_GROUP_BITS-1:0] rd_data_o,
    input  logic [`ICACHE_INDEX_BITS-1:0]                   wr_index_i,
    input  logic [1:0]                                      wr_word_i,
    input  logic [$clog2(`ICACHE_WAYS)-1:0]                 wr_way_i,
    input  logic                                            wr_tag_we_i,
    input  tag_entry_t                                      wr_tag_i,
    input  logic                                            wr_data_we_i,
    input  logic [`ICACHE_GROUP_BITS-1:0]                   wr_data_i,
    input  logic [`ICACHE_WAYS-1:0]                         inv_mask_i
);
    localparam int GROUPS = `ICACHE_SETS * `ICACHE_LINE_BEATS / 2;

    logic [`ICACHE_INDEX_BITS-1:0] rd_set;
    logic [`ICACHE_INDEX_BITS+1:0] wr_group;
    logic                          set_match;

    assign rd_set    = rd_index_i[`ICACHE_INDEX_BITS+1:2];
    assign wr_group  = {wr_index_i, wr_word_i};
    assign set_match = (rd_set == wr_index_i);

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic [`ICACHE_TAG_BITS-1:0]   tag_mem [`ICACHE_SETS];
        logic [`ICACHE_GROUP_BITS-1:0] data_mem [GROUPS];
        logic [`ICACHE_SETS-1:0]       valid_q;
        tag_entry_t                    tag_rd_q;
        logic [`ICACHE_GROUP_BITS-1:0] data_rd_q;
        logic                          tag_we;
        logic                          data_we;

        assign tag_we  = wr_tag_we_i && (wr_way_i == w);
        assign data_we = wr_data_we_i && (wr_way_i == w);

        always_ff @(posedge clk) begin
            if (tag_we) begin
                tag_mem[wr_index_i] <= wr_tag_i.tag;
            end
            if (data_we) begin
                data_mem[wr_group] <= wr_data_i;
            end
        end

        // invalidate wins over a tag write
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                valid_q <= '0;
            end else if (inv_mask_i[w]) begin
                valid_q[wr_index_i] <= 1'b0;
            end else if (tag_we) begin
                valid_q[wr_index_i] <= wr_tag_i.valid;
            end
        end

        // same-cycle write to the read address is forwarded
        always_ff @(posedge clk) begin
            if (set_match && inv_mask_i[w]) begin
                tag_rd_q <= '0;
            end else if (set_match && tag_we) begin
                tag_rd_q <= wr_tag_i;
            end else begin
                tag_rd_q <= '{valid: valid_q[rd_set], tag: tag_mem[rd_set]};
            end
            if (data_we && (rd_index_i == wr_group)) begin
                data_rd_q <= wr_data_i;
            end else begin
                data_rd_q <= data_mem[rd_index_i];
            end
        end

        assign rd_tags_o[w] = tag_rd_q;
        assign rd_data_o[w] = data_rd_q;
    end

endmodule

//--- icache/icache_lookup.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_lookup import icache_pkg::*; (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            flush_i,
    input  logic                                            fetch_valid_i,
    input  logic [31:0]                                     fetch_addr_i,
    output logic                                            fetch_ready_o,
    output logic                                            out_valid_o,
    output logic [`ICACHE_GROUP_BITS-1:0]                   out_insts_o,
    input  logic                                            out_ready_i,
    output logic [`ICACHE_INDEX_BITS+1:0]                   rd_index_o,
    input  tag_entry_t [`ICACHE_WAYS-1:0]                   rd_tags_i,
    input  logic [`ICACHE_WAYS-1:0][`ICACHE_GROUP_BITS-1:0] rd_data_i,
    output logic                                            miss_o,
    output logic [31:0]                                     miss_addr_o,
    input  logic                                            busy_i,
    input  logic                                            fill_done_i,
    input  logic [`ICACHE_GROUP_BITS-1:0]                   fill_insts_i
);
    localparam int GROUP_LSB = `ICACHE_OFFSET_BITS - 2;

    logic                          s1_valid_q;
    logic [31:0]                   s1_addr_q;
    logic [`ICACHE_WAYS-1:0]       way_hit;
    logic                          hit;
    logic [`ICACHE_GROUP_BITS-1:0] hit_insts;
    logic                          out_valid_q;
    logic [`ICACHE_GROUP_BITS-1:0] out_insts_q;
    logic                          out_free;
    logic                          s1_done;
    logic                          fetch_fire;
    logic [31:0]                   fetch_aligned;

    // misaligned pcs just drop to the group boundary
    assign fetch_aligned = {fetch_addr_i[31:GROUP_LSB], {GROUP_LSB{1'b0}}};

    always_comb begin
        hit_insts = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = rd_tags_i[w].valid &&
                         (rd_tags_i[w].tag == s1_addr_q[31 -: `ICACHE_TAG_BITS]);
            if (way_hit[w]) begin
                hit_insts = rd_data_i[w];
            end
        end
    end

    assign hit      = |way_hit;
    assign out_free = !out_valid_q || out_ready_i;
    assign s1_done  = s1_valid_q && (hit || fill_done_i) && out_free;

    assign fetch_ready_o = !busy_i && (!s1_valid_q || s1_done);
    assign fetch_fire    = fetch_valid_i && fetch_ready_o;

    // a waiting lookup keeps re-reading its own address
    assign rd_index_o = fetch_fire ? fetch_aligned[GROUP_LSB +: `ICACHE_INDEX_BITS+2]
                                   : s1_addr_q[GROUP_LSB +: `ICACHE_INDEX_BITS+2];

    assign miss_o      = s1_valid_q && !hit && !flush_i;
    assign miss_addr_o = s1_addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
        end else if (fetch_fire) begin
            s1_valid_q <= 1'b1;
        end else if (s1_done) begin
            s1_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            s1_addr_q <= fetch_aligned;
        end
    end

    // output stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            out_valid_q <= 1'b0;
        end else if (s1_done) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_done) begin
            out_insts_q <= fill_done_i ? fill_insts_i : hit_insts;
        end
    end

    assign out_valid_o = out_valid_q && !flush_i;
    assign out_insts_o = out_insts_q;

endmodule

//--- icache/icache_refill.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_refill import icache_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            miss_i,
    input  logic [31:0]                     miss_addr_i,
    output logic                            mem_req_valid_o,
    output logic [31:0]                     mem_addr_o,
    output logic [7:0]                      mem_len_o,
    input  logic                            mem_req_ready_i,
    input  logic                            mem_data_valid_i,
    input  logic [31:0]                     mem_data_i,
    input  logic                            cacop_valid_i,
    input  cacop_op_e                       cacop_op_i,
    input  logic [31:0]                     cacop_addr_i,
    output logic                            cacop_done_o,
    output logic [`ICACHE_INDEX_BITS-1:0]   wr_index_o,
    output logic [1:0]                      wr_word_o,
    output logic [$clog2(`ICACHE_WAYS)-1:0] wr_way_o,
    output logic                            wr_tag_we_o,
    output tag_entry_t                      wr_tag_o,
    output logic                            wr_data_we_o,
    output logic [`ICACHE_GROUP_BITS-1:0]   wr_data_o,
    output logic [`ICACHE_WAYS-1:0]         inv_mask_o,
    output logic                            busy_o,
    output logic                            fill_done_o,
    output logic [`ICACHE_GROUP_BITS-1:0]   fill_insts_o
);
    localparam int BEAT_BITS = $clog2(`ICACHE_LINE_BEATS);
    localparam logic [BEAT_BITS-1:0] LAST_BEAT = BEAT_BITS'(`ICACHE_LINE_BEATS - 1);

    refill_state_e                 state_q;
    refill_state_e                 state_d;
    logic [BEAT_BITS-1:0]          beat_q;
    logic [31:0]                   line_addr_q;
    logic [1:0]                    group_q;
    logic [31:0]                   low_word_q;
    logic [`ICACHE_GROUP_BITS-1:0] fill_insts_q;
    logic [`ICACHE_SETS-1:0]       repl_q;
    logic                          cacop_done_q;
    logic [`ICACHE_INDEX_BITS-1:0] line_set;
    logic                          beat_fire;
    logic                          cacop_take;
    logic                          miss_take;

    assign line_set   = line_addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign beat_fire  = (state_q == FILL) && mem_data_valid_i;
    // commit still holds the op in the cycle done is high
    assign cacop_take = (state_q == IDLE) && cacop_valid_i && !cacop_done_q;
    assign miss_take  = (state_q == IDLE) && !cacop_take && miss_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cacop_take) begin
                    state_d = CACOP;
                end else if (miss_take) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (mem_req_ready_i) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                if (beat_fire && (beat_q == LAST_BEAT)) begin
                    state_d = HOLD;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // beat counter wraps back to zero after the last beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            beat_q       <= '0;
            repl_q       <= '0;
            cacop_done_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            cacop_done_q <= (state_q == CACOP);
            if (beat_fire) begin
                beat_q <= beat_q + 1'b1;
            end
            if (wr_tag_we_o) begin
                repl_q[line_set] <= ~repl_q[line_set];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_take) begin
            line_addr_q <= {miss_addr_i[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
            group_q     <= miss_addr_i[`ICACHE_OFFSET_BITS-1 -: 2];
        end
        if (beat_fire && !beat_q[0]) begin
            low_word_q <= mem_data_i;
        end
        if (wr_data_we_o && (wr_word_o == group_q)) begin
            fill_insts_q <= wr_data_o;
        end
    end

    assign mem_req_valid_o = (state_q == REQ);
    assign mem_addr_o      = line_addr_q;
    assign mem_len_o       = 8'(`ICACHE_LINE_BEATS);

    // an odd beat completes a group with the upper word at the higher address
    assign wr_index_o   = (state_q == CACOP)
                        ? cacop_addr_i[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS]
                        : line_set;
    assign wr_word_o    = beat_q[BEAT_BITS-1:1];
    assign wr_way_o     = repl_q[line_set];
    assign wr_data_we_o = beat_fire && beat_q[0];
    assign wr_data_o    = {mem_data_i, low_word_q};
    assign wr_tag_we_o  = wr_data_we_o && (beat_q == LAST_BEAT);
    assign wr_tag_o     = '{valid: 1'b1, tag: line_addr_q[31 -: `ICACHE_TAG_BITS]};

    always_comb begin
        inv_mask_o = '0;
        if (state_q == CACOP) begin
            if (cacop_op_i == OP_INIT) begin
                inv_mask_o = '1;
            end else begin
                inv_mask_o[cacop_addr_i[0]] = 1'b1;
            end
        end
    end

    assign cacop_done_o = cacop_done_q;
    assign busy_o       = (state_q != IDLE);
    assign fill_done_o  = (state_q == HOLD);
    assign fill_insts_o = fill_insts_q;

endmodule

//--- icache/icache_top.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top import icache_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush_i,
    input  logic                          fetch_valid_i,
    input  logic [31:0]                   fetch_addr_i,
    output logic                          fetch_ready_o,
    output logic                          out_valid_o,
    output logic [`ICACHE_GROUP_BITS-1:0] out_insts_o,
    input  logic                          out_ready_i,
    output logic                          mem_req_valid_o,
    output logic [31:0]                   mem_addr_o,
    output logic [7:0]                    mem_len_o,
    input  logic                          mem_req_ready_i,
    input  logic                          mem_data_valid_i,
    input  logic [31:0]                   mem_data_i,
    input  logic                          cacop_valid_i,
    input  cacop_op_e                     cacop_op_i,
    input  logic [31:0]                   cacop_addr_i,
    output logic                          cacop_done_o
);
    logic [`ICACHE_INDEX_BITS+1:0]                   rd_index;
    tag_entry_t [`ICACHE_WAYS-1:0]                   rd_tags;
    logic [`ICACHE_WAYS-1:0][`ICACHE_GROUP_BITS-1:0] rd_data;
    logic [`ICACHE_INDEX_BITS-1:0]                   wr_index;
    logic [1:0]                                      wr_word;
    logic [$clog2(`ICACHE_WAYS)-1:0]                 wr_way;
    logic                                            wr_tag_we;
    tag_entry_t                                      wr_tag;
    logic                                            wr_data_we;
    logic [`ICACHE_GROUP_BITS-1:0]                   wr_data;
    logic [`ICACHE_WAYS-1:0]                         inv_mask;
    logic                                            miss;
    logic [31:0]                                     miss_addr;
    logic                                            busy;
    logic                                            fill_done;
    logic [`ICACHE_GROUP_BITS-1:0]                   fill_insts;

    icache_lookup i_lookup (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_ready_o (fetch_ready_o),
        .out_valid_o   (out_valid_o),
        .out_insts_o   (out_insts_o),
        .out_ready_i   (out_ready_i),
        .rd_index_o    (rd_index),
        .rd_tags_i     (rd_tags),
        .rd_data_i     (rd_data),
        .miss_o        (miss),
        .miss_addr_o   (miss_addr),
        .busy_i        (busy),
        .fill_done_i   (fill_done),
        .fill_insts_i  (fill_insts)
    );

    icache_arrays i_arrays (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_index_i   (rd_index),
        .rd_tags_o    (rd_tags),
        .rd_data_o    (rd_data),
        .wr_index_i   (wr_index),
        .wr_word_i    (wr_word),
        .wr_way_i     (wr_way),
        .wr_tag_we_i  (wr_tag_we),
        .wr_tag_i     (wr_tag),
        .wr_data_we_i (wr_data_we),
        .wr_data_i    (wr_data),
        .inv_mask_i   (inv_mask)
    );

    icache_refill i_refill (
        .clk              (clk),
        .rst_n            (rst_n),
        .miss_i           (miss),
        .miss_addr_i      (miss_addr),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_addr_o       (mem_addr_o),
        .mem_len_o        (mem_len_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .cacop_valid_i    (cacop_valid_i),
        .cacop_op_i       (cacop_op_i),
        .cacop_addr_i     (cacop_addr_i),
        .cacop_done_o     (cacop_done_o),
        .wr_index_o       (wr_index),
        .wr_word_o        (wr_word),
        .wr_way_o         (wr_way),
        .wr_tag_we_o      (wr_tag_we),
        .wr_tag_o         (wr_tag),
        .wr_data_we_o     (wr_data_we),
        .wr_data_o        (wr_data),
        .inv_mask_o       (inv_mask),
        .busy_o           (busy),
        .fill_done_o      (fill_done),
        .fill_insts_o     (fill_insts)
    );

endmodule

//--- list.f
+incdir+common
common/icache_pkg.sv
icache/icache_arrays.sv
icache/icache_lookup.sv
icache/icache_refill.sv
icache/icache_top.sv
test/mem_model.sv
test/tb_icache.sv

//--- test/icache_input.txt
# name kind op addr req
# op is the cacop opcode (0 init, 1 idx_inv) or the group count of a stream
# req is the number of line requests the record must cause
cold_fetch         fetch   0  00001040  1
same_line_a        fetch   0  00001048  0
same_line_b        fetch   0  0000105c  0
misaligned_pc      fetch   0  00001046  0
evict_first        fetch   0  000020a0  1
evict_second       fetch   0  000030a8  1
evict_third        fetch   0  000040b0  1
refetch_first      fetch   0  000020b8  1
refetch_third      fetch   0  000040a0  0
cacop_init         cacop   0  00000040  0
after_init         fetch   0  00001040  1
inv_other_way      cacop   1  00000040  0
after_inv_other    fetch   0  00001050  0
inv_line_way       cacop   1  00000041  0
after_inv_line     fetch   0  00001050  1
stream_cold        stream  12 00006000  3
stream_warm        stream  12 00006000  0
stream_mixed       stream  8  00001040  1
flush_early        flush   0  00007000  0
after_flush_early  fetch   0  00007000  1
flush_late         flush   0  00008020  1
after_flush_late   fetch   0  00008028  0

//--- test/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] KEY = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall_i,
    input  logic        req_valid_i,
    input  logic [31:0] addr_i,
    input  logic [7:0]  len_i,
    output logic        req_ready_o,
    output logic        data_valid_o,
    output logic [31:0] data_o
);
    logic        active_q;
    logic        stall_q;
    logic [31:0] next_addr_q;
    logic [7:0]  left_q;

    initial begin
        req_ready_o  = 1'b0;
        data_valid_o = 1'b0;
        data_o       = '0;
    end

    // request accept and beat consume both happen at the rising edge
    always @(posedge clk) begin
        stall_q <= stall_i;
        if (!rst_n) begin
            active_q <= 1'b0;
            left_q   <= '0;
        end else if (req_valid_i && req_ready_o) begin
            active_q    <= 1'b1;
            next_addr_q <= addr_i;
            left_q      <= len_i;
        end else if (data_valid_o) begin
            next_addr_q <= next_addr_q + 32'd4;
            left_q      <= left_q - 8'd1;
            if (left_q == 8'd1) begin
                active_q <= 1'b0;
            end
        end
    end

    // word at byte address A reads as A xor KEY
    always @(negedge clk) begin
        req_ready_o  <= rst_n && !active_q && !stall_q;
        data_valid_o <= active_q && !stall_q;
        data_o       <= active_q ? (next_addr_q ^ KEY) : '0;
    end

endmodule

//--- test/tb_icache.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module tb_icache import icache_pkg::*; ();
    localparam logic [31:0] MEM_KEY = 32'hc3a5_5a3c;
    localparam int LIMIT = 2000;

    logic                          clk;
    logic                          rst_n;
    logic                          flush;
    logic                          fetch_valid;
    logic [31:0]                   fetch_addr;
    logic                          fetch_ready;
    logic                          out_valid;
    logic [`ICACHE_GROUP_BITS-1:0] out_insts;
    logic                          out_ready;
    logic                          mem_req_valid;
    logic [31:0]                   mem_addr;
    logic [7:0]                    mem_len;
    logic                          mem_req_ready;
    logic                          mem_data_valid;
    logic [31:0]                   mem_data;
    logic                          cacop_valid;
    cacop_op_e                     cacop_op;
    logic [31:0]                   cacop_addr;
    logic                          cacop_done;
    logic                          mem_stall;
    logic                          random_ready;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          req_count = 0;
    logic [31:0] last_req_addr = '0;
    logic [63:0] exp_q[$];
    logic [255:0] name_q[$];
    logic        held = 1'b0;
    logic [63:0] held_insts;

    icache_top i_dut (
        .clk(clk), .rst_n(rst_n), .flush_i(flush),
        .fetch_valid_i(fetch_valid), .fetch_addr_i(fetch_addr), .fetch_ready_o(fetch_ready),
        .out_valid_o(out_valid), .out_insts_o(out_insts), .out_ready_i(out_ready),
        .mem_req_valid_o(mem_req_valid), .mem_addr_o(mem_addr), .mem_len_o(mem_len),
        .mem_req_ready_i(mem_req_ready), .mem_data_valid_i(mem_data_valid),
        .mem_data_i(mem_data), .cacop_valid_i(cacop_valid), .cacop_op_i(cacop_op),
        .cacop_addr_i(cacop_addr), .cacop_done_o(cacop_done)
    );

    mem_model #(.KEY(MEM_KEY)) i_mem (
        .clk(clk), .rst_n(rst_n), .stall_i(mem_stall),
        .req_valid_i(mem_req_valid), .addr_i(mem_addr), .len_i(mem_len),
        .req_ready_o(mem_req_ready), .data_valid_o(mem_data_valid), .data_o(mem_data)
    );

    always #20 clk = ~clk;

    // two words from the memory rule with the upper word at the higher address
    function automatic logic [63:0] group_for(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:3], 3'b000};
        return {(base + 32'd4) ^ MEM_KEY, base ^ MEM_KEY};
    endfunction

    task automatic check_value(input logic [255:0] name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %0s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_totals();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    endtask

    task automatic stop_on_timeout(input logic [255:0] what);
        errors++;
        $display("timed out waiting for %0s", what);
        report_totals();
        $display("RESULT: FAIL");
        $finish;
    endtask

    // one sample per cycle after the falling-edge drives settle
    task automatic watch_cycle();
        logic [255:0] name;
        if (mem_req_valid && mem_req_ready) begin
            req_count++;
            last_req_addr = mem_addr;
            check_value("mem_len", 64'd8, 64'(mem_len));
            check_value("mem_addr alignment", 64'd0, 64'(mem_addr[4:0]));
        end
        name = (name_q.size() != 0) ? name_q[0] : "stalled output";
        if (flush) begin
            held = 1'b0;
        end else if (out_valid) begin
            if (held) begin
                check_value(name, held_insts, out_insts);
            end
            if (!out_ready) begin
                held = 1'b1;
                held_insts = out_insts;
            end else if (exp_q.size() == 0) begin
                errors++;
                held = 1'b0;
                $display("output group %h appeared with no fetch waiting for it", out_insts);
            end else begin
                held = 1'b0;
                check_value(name_q.pop_front(), exp_q.pop_front(), out_insts);
            end
        end else if (held) begin
            errors++;
            held = 1'b0;
            $display("output valid dropped while the decoder was stalling");
        end
    endtask

    task automatic fetch_one(input logic [255:0] name, input logic [31:0] addr,
                             input logic expect_out);
        int   n;
        logic taken;
        n = 0;
        taken = 1'b0;
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_addr = addr;
        while (!taken) begin
            #1;
            if (fetch_ready) begin
                taken = 1'b1;
            end else begin
                n++;
                if (n > LIMIT) stop_on_timeout("fetch_ready");
                @(negedge clk);
            end
        end
        if (expect_out) begin
            exp_q.push_back(group_for(addr));
            name_q.push_back(name);
        end
    endtask

    task automatic release_fetch();
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            n++;
            if (n > LIMIT) stop_on_timeout("output groups");
            @(negedge clk);
            #2;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        #1;
        while (!fetch_ready) begin
            n++;
            if (n > LIMIT) stop_on_timeout("the cache to go idle");
            @(negedge clk);
            #1;
        end
    endtask

    // done is expected on the second sample after the op is driven
    task automatic issue_cacop(input logic [255:0] name, input int op, input logic [31:0] addr);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        @(negedge clk);
        cacop_valid = 1'b1;
        cacop_op = cacop_op_e'(op[1:0]);
        cacop_addr = addr;
        while (!seen) begin
            #1;
            if (cacop_done) begin
                seen = 1'b1;
            end else begin
                n++;
                if (n > LIMIT) stop_on_timeout("cacop_done");
                @(negedge clk);
            end
        end
        check_value(name, 64'd2, 64'(n));
        @(negedge clk);
        cacop_valid = 1'b0;
    endtask

    task automatic stream_groups(input logic [255:0] name, input logic [31:0] base,
                                 input int count);
        random_ready = 1'b1;
        for (int i = 0; i < count; i++) begin
            fetch_one(name, base + 32'(8 * i), 1'b1);
        end
        release_fetch();
        wait_drained();
        random_ready = 1'b0;
    endtask

    // with late set the flush comes once the line request is out
    task automatic flush_pending(input logic [255:0] name, input logic [31:0] addr,
                                 input logic late);
        int n;
        n = 0;
        fetch_one(name, addr, 1'b0);
        @(negedge clk);
        fetch_valid = 1'b0;
        if (late) begin
            #1;
            while (!mem_req_valid) begin
                n++;
                if (n > LIMIT) stop_on_timeout("mem_req_valid");
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        wait_ready();
    endtask

    task automatic run_record(input logic [255:0] name, input logic [255:0] kind,
                              input int op, input logic [31:0] addr, input int req_exp);
        int req_before;
        tests++;
        req_before = req_count;
        if (kind == "fetch") begin
            fetch_one(name, addr, 1'b1);
            release_fetch();
            wait_drained();
        end else if (kind == "cacop") begin
            issue_cacop(name, op, addr);
        end else if (kind == "stream") begin
            stream_groups(name, addr, op);
        end else if (kind == "flush") begin
            flush_pending(name, addr, req_exp != 0);
        end else begin
            errors++;
            $display("unknown record kind %0s in test %0s", kind, name);
        end
        check_value(name, 64'(req_exp), 64'(req_count - req_before));
        if (kind == "fetch" && req_exp == 1) begin
            check_value(name, {32'd0, addr[31:5], 5'b00000}, {32'd0, last_req_addr});
        end
    endtask

    initial begin : drive_and_watch
        void'($urandom(328));
        out_ready = 1'b1;
        mem_stall = 1'b0;
        forever begin
            @(negedge clk);
            out_ready = random_ready ? (($urandom % 3) != 0) : 1'b1;
            mem_stall = (($urandom % 4) == 0);
            #1;
            watch_cycle();
        end
    end

    initial begin : main
        logic [8*160-1:0] line;
        logic [255:0]     name;
        logic [255:0]     kind;
        logic [31:0]      addr;
        int               op;
        int               req_exp;
        int               fd;
        int               code;
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr = '0;
        cacop_valid = 1'b0;
        cacop_op = OP_INIT;
        cacop_addr = '0;
        random_ready = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        #2;
        check_value("reset fetch_ready", 64'd1, 64'(fetch_ready));
        check_value("reset out_valid", 64'd0, 64'(out_valid));
        check_value("reset mem_req_valid", 64'd0, 64'(mem_req_valid));
        check_value("reset cacop_done", 64'd0, 64'(cacop_done));
        fd = $fopen("test/icache_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file test/icache_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                code = $fgets(line, fd);
                if (code > 0) begin
                    code = $sscanf(line, "%s %s %d %h %d", name, kind, op, addr, req_exp);
                    if (code == 5) begin
                        run_record(name, kind, op, addr, req_exp);
                    end
                end
            end
            $fclose(fd);
        end
        if (tests == 0) begin
            errors++;
            $display("no test records were read");
        end
        report_totals();
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
